// File: source/hci_defines.svh
// hci subsystem parameters for channel count, address, data and byte widths and FIFO depth
`ifndef HCI_DEFINES_SVH
`define HCI_DEFINES_SVH

// number of initiator channels into the shared bank
`define HCI_NB_CHAN 4

// id width as log2 of the channel count
`define HCI_IW 2

// word address width so the bank holds 2**HCI_AW words
`define HCI_AW 8

// data word and byte widths giving DW/BW byte enables per word
`define HCI_DW 32
`define HCI_BW 8

// default depth of the memory-side request FIFO
`define HCI_FIFO_DEPTH 4

`endif

// File: source/hci_pkg.sv
// hci shared types: channel-side and memory-side request/response structs
`include "hci_defines.svh"

package hci_pkg;

  // request from one initiator channel
  // wen high means read, low means write
  typedef struct packed {
    logic                           req;
    logic                           wen;
    logic [`HCI_AW-1:0]             add;
    logic [`HCI_DW-1:0]             data;
    logic [`HCI_DW/`HCI_BW-1:0]     be;
    logic                           r_ready;
  } hci_chan_req_t;

  // response back to one initiator channel
  typedef struct packed {
    logic                           gnt;
    logic                           r_valid;
    logic [`HCI_DW-1:0]             r_data;
  } hci_chan_rsp_t;

  // tagged request on the memory side
  // id carries the number of the channel that issued it
  typedef struct packed {
    logic                           req;
    logic                           wen;
    logic [`HCI_AW-1:0]             add;
    logic [`HCI_DW-1:0]             data;
    logic [`HCI_DW/`HCI_BW-1:0]     be;
    logic [`HCI_IW-1:0]             id;
  } hci_mem_req_t;

  // response on the memory side
  // r_id is the reflected request id, r_ready travels beside it as a plain level
  typedef struct packed {
    logic                           gnt;
    logic                           r_valid;
    logic [`HCI_DW-1:0]             r_data;
    logic [`HCI_IW-1:0]             r_id;
  } hci_mem_rsp_t;

endpackage

// File: source/hci_ooo_mux.sv
// hci out-of-order mux: arbitrates N channels into one id-tagged stream, routes responses by id
`include "hci_defines.svh"

module hci_ooo_mux
  import hci_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear_i,

  input  logic                                  priority_force_i,
  input  logic [`HCI_NB_CHAN-1:0][`HCI_IW-1:0]  priority_i,

  input  hci_chan_req_t [`HCI_NB_CHAN-1:0]      chan_req,
  output hci_chan_rsp_t [`HCI_NB_CHAN-1:0]      chan_rsp,

  output hci_mem_req_t                          mem_req,
  input  hci_mem_rsp_t                          mem_rsp,
  output logic                                  mem_r_ready
);

  localparam int unsigned nb_chan = `HCI_NB_CHAN;
  localparam int unsigned iw      = `HCI_IW;

  logic [iw-1:0]              rr_cnt_q;
  logic [nb_chan-1:0][iw-1:0] prio_list;
  logic [iw-1:0]              winner;
  logic                       mem_hs;

  // one transfer into the FIFO per cycle at most
  assign mem_hs = mem_req.req & mem_rsp.gnt;

  // round-robin pointer, moves one slot per memory-side transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_cnt_q <= '0;
    end else if (clear_i) begin
      rr_cnt_q <= '0;
    end else if (mem_hs) begin
      if (rr_cnt_q == iw'(nb_chan - 1)) begin
        rr_cnt_q <= '0;
      end else begin
        rr_cnt_q <= rr_cnt_q + 1'b1;
      end
    end
  end

  // priority list, rank 0 is checked first
  // forced mode takes the outside list as is
  for (genvar r = 0; r < nb_chan; r++) begin : gen_prio
    assign prio_list[r] = priority_force_i ? priority_i[r] :
                          iw'((int'(rr_cnt_q) + r) % nb_chan);
  end

  // first rank whose channel has req high wins
  // no request at all falls back to the counter, gnt stays low anyway
  always_comb begin
    logic found;
    found  = 1'b0;
    winner = rr_cnt_q;
    for (int r = 0; r < nb_chan; r++) begin
      if (!found && chan_req[prio_list[r]].req) begin
        winner = prio_list[r];
        found  = 1'b1;
      end
    end
  end

  // forward winner fields, tag with its channel number
  always_comb begin
    mem_req.req  = chan_req[winner].req;
    mem_req.wen  = chan_req[winner].wen;
    mem_req.add  = chan_req[winner].add;
    mem_req.data = chan_req[winner].data;
    mem_req.be   = chan_req[winner].be;
    mem_req.id   = winner;
  end

  // response side: ready comes from the channel that owns the returning id
  assign mem_r_ready = chan_req[mem_rsp.r_id].r_ready;

  for (genvar i = 0; i < nb_chan; i++) begin : gen_chan_rsp
    // gnt only to the winner, and only while it asks
    assign chan_rsp[i].gnt     = (winner == iw'(i)) & chan_req[i].req & mem_rsp.gnt;
    // valid steered by the reflected id
    assign chan_rsp[i].r_valid = (mem_rsp.r_id == iw'(i)) & mem_rsp.r_valid;
    // data is shared, valid picks the receiver
    assign chan_rsp[i].r_data  = mem_rsp.r_data;
  end

endmodule

// File: source/hci_req_fifo.sv
// hci request FIFO: registered circular buffer between mux and bank, id passed through untouched
`include "hci_defines.svh"

module hci_req_fifo
  import hci_pkg::*;
#(
  parameter int unsigned depth = `HCI_FIFO_DEPTH
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,

  input  hci_mem_req_t in_req,
  output logic         in_gnt,

  output hci_mem_req_t out_req,
  input  logic         out_gnt
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  hci_mem_req_t     fifo_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] cnt_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  assign full  = (cnt_q == cnt_w'(depth));
  assign empty = (cnt_q == '0);

  // accept whenever a slot is free
  assign in_gnt = ~full;
  assign push   = in_req.req & ~full;
  assign pop    = out_req.req & out_gnt;

  // head entry, req rebuilt from occupancy
  always_comb begin
    out_req     = fifo_q[rd_ptr_q];
    out_req.req = ~empty;
  end

  // entry storage, whole tagged request
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= in_req;
    end
  end

  // pointers wrap at depth, not at a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // occupancy, simultaneous push and pop leaves it unchanged
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

// File: source/hci_mem_bank.sv
// hci memory bank: byte-enabled word memory, one-cycle response that reflects the request id
`include "hci_defines.svh"

module hci_mem_bank
  import hci_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  input  hci_mem_req_t mem_req,
  output logic         gnt,
  input  logic         r_ready,
  output hci_mem_rsp_t rsp
);

  localparam int unsigned nwords = 1 << `HCI_AW;
  localparam int unsigned dw     = `HCI_DW;
  localparam int unsigned bw     = `HCI_BW;
  localparam int unsigned nbe    = dw / bw;

  logic [dw-1:0]      mem_q [nwords];
  logic               rsp_valid_q;
  logic [dw-1:0]      rsp_data_q;
  logic [`HCI_IW-1:0] rsp_id_q;
  logic               req_hs;

  // single response slot, free when empty or drained this cycle
  assign gnt    = mem_req.req & (~rsp_valid_q | r_ready);
  assign req_hs = mem_req.req & gnt;

  // storage, cleared at reset so unwritten words read as zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < nwords; w++) begin
        mem_q[w] <= '0;
      end
    end else if (req_hs && !mem_req.wen) begin
      // only enabled bytes change
      for (int b = 0; b < nbe; b++) begin
        if (mem_req.be[b]) begin
          mem_q[mem_req.add][b*bw +: bw] <= mem_req.data[b*bw +: bw];
        end
      end
    end
  end

  // response valid, set on grant, dropped once consumed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (req_hs) begin
      rsp_valid_q <= 1'b1;
    end else if (r_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // response payload, writes return zero data
  // id is reflected unchanged for the mux to route on
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      rsp_data_q <= mem_req.wen ? mem_q[mem_req.add] : '0;
      rsp_id_q   <= mem_req.id;
    end
  end

  assign rsp.gnt     = gnt;
  assign rsp.r_valid = rsp_valid_q;
  assign rsp.r_data  = rsp_data_q;
  assign rsp.r_id    = rsp_id_q;

endmodule

// File: source/hci_ooo_subsystem.sv
// hci out-of-order subsystem: four channels through mux and request FIFO into one memory bank
`include "hci_defines.svh"

module hci_ooo_subsystem
  import hci_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear_i,

  input  logic                                  priority_force_i,
  input  logic [`HCI_NB_CHAN-1:0][`HCI_IW-1:0]  priority_i,

  input  hci_chan_req_t [`HCI_NB_CHAN-1:0]      chan_req,
  output hci_chan_rsp_t [`HCI_NB_CHAN-1:0]      chan_rsp
);

  // mux to FIFO
  hci_mem_req_t mux_req;
  hci_mem_rsp_t mux_rsp;
  logic         fifo_gnt;
  logic         mux_r_ready;

  // FIFO to bank
  hci_mem_req_t bank_req;
  logic         bank_gnt;
  hci_mem_rsp_t bank_rsp;

  // gnt from the FIFO, response straight from the bank
  assign mux_rsp.gnt     = fifo_gnt;
  assign mux_rsp.r_valid = bank_rsp.r_valid;
  assign mux_rsp.r_data  = bank_rsp.r_data;
  assign mux_rsp.r_id    = bank_rsp.r_id;

  hci_ooo_mux mux0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (clear_i),
    .priority_force_i (priority_force_i),
    .priority_i       (priority_i),
    .chan_req         (chan_req),
    .chan_rsp         (chan_rsp),
    .mem_req          (mux_req),
    .mem_rsp          (mux_rsp),
    .mem_r_ready      (mux_r_ready)
  );

  hci_req_fifo #(
    .depth (`HCI_FIFO_DEPTH)
  ) fifo0 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .in_req  (mux_req),
    .in_gnt  (fifo_gnt),
    .out_req (bank_req),
    .out_gnt (bank_gnt)
  );

  // bank sits at the memory boundary and reflects ids
  hci_mem_bank bank0 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .mem_req (bank_req),
    .gnt     (bank_gnt),
    .r_ready (mux_r_ready),
    .rsp     (bank_rsp)
  );

endmodule

// File: bench/tb_hci_checker.sv
// hci testbench checker: models arbitration and memory per channel, compares and counts errors
`include "hci_defines.svh"

module tb_hci_checker
  import hci_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 clear_i,
  input  logic                                 priority_force_i,
  input  logic [`HCI_NB_CHAN-1:0][`HCI_IW-1:0] priority_i,
  input  hci_chan_req_t [`HCI_NB_CHAN-1:0]     chan_req,
  input  hci_chan_rsp_t [`HCI_NB_CHAN-1:0]     chan_rsp,
  input  logic                                 test_end,
  input  logic                                 run_end,
  output int                                   outstanding,
  output int                                   err_cnt
);

  localparam int nb      = `HCI_NB_CHAN;
  localparam int bw      = `HCI_BW;
  localparam int nbe     = `HCI_DW / `HCI_BW;
  localparam int buf_len = 32;
  localparam int max_fly = `HCI_FIFO_DEPTH + 2;

  // byte model per channel, zero like the bank after reset
  logic [bw-1:0]      model_mem [nb][1 << `HCI_AW][nbe];
  // expected r_data per channel in grant order
  logic [`HCI_DW-1:0] exp_buf [nb][buf_len];
  int                 head [nb];
  int                 cnt [nb];
  int                 rr_m;
  int                 checks;
  int                 test_no;
  int                 checks_mark;
  int                 err_mark;

  initial begin
    err_cnt     = 0;
    checks      = 0;
    test_no     = 0;
    checks_mark = 0;
    err_mark    = 0;
    for (int c = 0; c < nb; c++) begin
      for (int w = 0; w < (1 << `HCI_AW); w++) begin
        for (int b = 0; b < nbe; b++) begin
          model_mem[c][w][b] = '0;
        end
      end
    end
  end

  // granted request goes into the model, write responses carry zero data
  task automatic record_grant(input int ch);
    logic [`HCI_DW-1:0] word;
    word = '0;
    for (int b = 0; b < nbe; b++) begin
      if (!chan_req[ch].wen && chan_req[ch].be[b]) begin
        model_mem[ch][chan_req[ch].add][b] = chan_req[ch].data[b*bw +: bw];
      end
      if (chan_req[ch].wen) begin
        word[b*bw +: bw] = model_mem[ch][chan_req[ch].add][b];
      end
    end
    if (cnt[ch] == buf_len) begin
      $display("Error at time %0t: too many requests pending on channel %0d", $time, ch);
      err_cnt++;
    end else begin
      exp_buf[ch][(head[ch] + cnt[ch]) % buf_len] = word;
      cnt[ch]++;
    end
    outstanding++;
    if (outstanding > max_fly) begin
      $display("Error at time %0t: more than %0d requests granted while stalled", $time, max_fly);
      err_cnt++;
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin : watch
    int exp_w;
    int ch;
    int n_gnt;
    int g_ch;
    int n_valid;
    if (!rst_ni) begin
      rr_m        = 0;
      outstanding = 0;
      for (int i = 0; i < nb; i++) begin
        head[i] = 0;
        cnt[i]  = 0;
      end
    end else begin
      // responses, only the owner of the id may see r_valid
      n_valid = 0;
      for (int i = 0; i < nb; i++) begin
        if (chan_rsp[i].r_valid) begin
          n_valid++;
          if (cnt[i] == 0) begin
            $display("Error at time %0t: response on channel %0d with no request pending",
                     $time, i);
            err_cnt++;
          end else if (chan_req[i].r_ready) begin
            checks++;
            if (chan_rsp[i].r_data !== exp_buf[i][head[i]]) begin
              $display("Fail at time %0t: chan_rsp[%0d].r_data expected %h actual %h",
                       $time, i, exp_buf[i][head[i]], chan_rsp[i].r_data);
              err_cnt++;
            end
            head[i] = (head[i] + 1) % buf_len;
            cnt[i]--;
            outstanding--;
          end
        end
      end
      if (n_valid > 1) begin
        $display("Error at time %0t: r_valid high on %0d channels at once", $time, n_valid);
        err_cnt++;
      end
      // expected winner, first requesting channel in rank order
      exp_w = -1;
      for (int r = 0; r < nb; r++) begin
        ch = priority_force_i ? int'(priority_i[r]) : (rr_m + r) % nb;
        if (exp_w < 0 && chan_req[ch].req) begin
          exp_w = ch;
        end
      end
      n_gnt = 0;
      g_ch  = -1;
      for (int i = 0; i < nb; i++) begin
        if (chan_rsp[i].gnt) begin
          n_gnt++;
          g_ch = i;
        end
      end
      if (n_gnt > 1) begin
        $display("Error at time %0t: gnt high on %0d channels at once", $time, n_gnt);
        err_cnt++;
      end else if (n_gnt == 1) begin
        checks++;
        if (g_ch != exp_w) begin
          $display("Fail at time %0t: chan_rsp.gnt channel expected %0d actual %0d",
                   $time, exp_w, g_ch);
          err_cnt++;
        end
        record_grant(g_ch);
      end
      // pointer model, clear wins over a transfer
      if (clear_i) begin
        rr_m = 0;
      end else if (n_gnt > 0) begin
        rr_m = (rr_m + 1) % nb;
      end
      if (test_end) begin
        $display("test %0d finished: %0d checks, %0d errors",
                 test_no, checks - checks_mark, err_cnt - err_mark);
        test_no++;
        checks_mark = checks;
        err_mark    = err_cnt;
      end
      if (run_end) begin
        for (int i = 0; i < nb; i++) begin
          if (cnt[i] != 0) begin
            $display("Error: %0d requests on channel %0d were never answered", cnt[i], i);
            err_cnt++;
          end
        end
        $display("%0d tests, %0d checks, %0d errors", test_no, checks, err_cnt);
      end
    end
  end

endmodule

// File: bench/tb_hci_ooo.sv
// hci out-of-order testbench top with clock, reset, stimulus table, drive loop and watchdog
`include "hci_defines.svh"

module tb_hci_ooo
  import hci_pkg::*;
();

  localparam int nb_chan   = `HCI_NB_CHAN;
  localparam int clk_per   = 100;
  localparam int n_rows    = 14;
  localparam int stall_cyc = 8;

  // one table row where every masked channel issues a burst of requests
  typedef struct packed {
    logic [`HCI_NB_CHAN-1:0]              mask;
    logic                                 wen;
    logic [`HCI_AW-`HCI_IW-1:0]           offs;
    logic [`HCI_DW-1:0]                   data;
    logic [`HCI_DW/`HCI_BW-1:0]           be;
    logic [1:0]                           burst;
    logic                                 rnd;
    logic [`HCI_NB_CHAN-1:0]              rdy;
    logic                                 prio_force;
    logic [`HCI_NB_CHAN-1:0][`HCI_IW-1:0] prio;
    logic                                 clear;
  } stim_t;

  logic                                 clk_i;
  logic                                 rst_ni;
  logic                                 clear_i;
  logic                                 priority_force_i;
  logic [`HCI_NB_CHAN-1:0][`HCI_IW-1:0] priority_i;
  hci_chan_req_t [`HCI_NB_CHAN-1:0]     chan_req;
  hci_chan_rsp_t [`HCI_NB_CHAN-1:0]     chan_rsp;
  logic [`HCI_NB_CHAN-1:0]              gnt_seen;
  logic                                 test_end;
  logic                                 run_end;
  int                                   outstanding;
  int                                   err_cnt;
  int                                   seed;
  stim_t                                stim [n_rows];

  hci_ooo_subsystem dut0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (clear_i),
    .priority_force_i (priority_force_i),
    .priority_i       (priority_i),
    .chan_req         (chan_req),
    .chan_rsp         (chan_rsp)
  );

  tb_hci_checker chk0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (clear_i),
    .priority_force_i (priority_force_i),
    .priority_i       (priority_i),
    .chan_req         (chan_req),
    .chan_rsp         (chan_rsp),
    .test_end         (test_end),
    .run_end          (run_end),
    .outstanding      (outstanding),
    .err_cnt          (err_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_per / 2) clk_i = ~clk_i;
  end

  // transfers seen at the rising edge and read by the driver at the falling edge
  always @(posedge clk_i) begin
    for (int ch = 0; ch < nb_chan; ch++) begin
      gnt_seen[ch] <= chan_rsp[ch].gnt & chan_req[ch].req;
    end
  end

  function automatic stim_t make_row(
    input logic [`HCI_NB_CHAN-1:0]              mask,
    input logic                                 wen,
    input logic [`HCI_AW-`HCI_IW-1:0]           offs,
    input logic [`HCI_DW-1:0]                   data,
    input logic [`HCI_DW/`HCI_BW-1:0]           be,
    input logic [1:0]                           burst,
    input logic                                 rnd,
    input logic [`HCI_NB_CHAN-1:0]              rdy,
    input logic                                 prio_force,
    input logic [`HCI_NB_CHAN-1:0][`HCI_IW-1:0] prio,
    input logic                                 clear
  );
    return {mask, wen, offs, data, be, burst, rnd, rdy, prio_force, prio, clear};
  endfunction

  // load request k of a burst into the channel's own address quarter
  task automatic load_request(input int ch, input stim_t s, input int k);
    logic [`HCI_IW-1:0]        id;
    logic [`HCI_AW-`HCI_IW-1:0] offs_k;
    id     = ch[`HCI_IW-1:0];
    offs_k = s.offs + k[`HCI_AW-`HCI_IW-1:0];
    chan_req[ch].req  = 1'b1;
    chan_req[ch].wen  = s.wen;
    chan_req[ch].add  = {id, offs_k};
    chan_req[ch].be   = s.be;
    chan_req[ch].data = s.rnd ? $random(seed) : s.data + (ch << 8) + k;
  endtask

  task automatic apply_row(input stim_t s);
    int   left [nb_chan];
    int   sent [nb_chan];
    int   cyc;
    logic busy;
    priority_force_i = s.prio_force;
    priority_i       = s.prio;
    if (s.clear) begin
      clear_i = 1'b1;
      @(negedge clk_i);
      clear_i = 1'b0;
    end
    for (int ch = 0; ch < nb_chan; ch++) begin
      chan_req[ch].r_ready = s.rdy[ch];
      left[ch] = s.mask[ch] ? int'(s.burst) : 0;
      sent[ch] = 0;
      if (left[ch] > 0) begin
        load_request(ch, s, 0);
      end
    end
    cyc  = 0;
    busy = 1'b1;
    // hold each req until its gnt and release stalled channels after stall_cyc cycles
    while (busy) begin
      @(negedge clk_i);
      cyc++;
      busy = 1'b0;
      for (int ch = 0; ch < nb_chan; ch++) begin
        if (cyc == stall_cyc) begin
          chan_req[ch].r_ready = 1'b1;
        end
        if (gnt_seen[ch]) begin
          left[ch]--;
          sent[ch]++;
          if (left[ch] > 0) begin
            load_request(ch, s, sent[ch]);
          end else begin
            chan_req[ch].req = 1'b0;
          end
        end
        if (left[ch] > 0) begin
          busy = 1'b1;
        end
      end
    end
    for (int ch = 0; ch < nb_chan; ch++) begin
      chan_req[ch].r_ready = 1'b1;
    end
    // drain every response before the next row
    while (outstanding != 0) begin
      @(negedge clk_i);
    end
    test_end = 1'b1;
    @(negedge clk_i);
    test_end = 1'b0;
  endtask

  initial begin : main
    seed             = 84;
    rst_ni           = 1'b0;
    clear_i          = 1'b0;
    priority_force_i = 1'b0;
    priority_i       = '0;
    chan_req         = '0;
    test_end         = 1'b0;
    run_end          = 1'b0;
    // mask     wen  offs  data       be      burst rnd  rdy     force  prio  clear
    stim[0]  = make_row('hf, 0, 0, 'h1111_0000, 'hf, 2, 0, 'hf, 0, 'h00, 1);
    stim[1]  = make_row('hf, 1, 0, 'h0, 'hf, 2, 0, 'hf, 0, 'h00, 0);
    stim[2]  = make_row('hf, 1, 8, 'h0, 'hf, 1, 0, 'hf, 0, 'h00, 0);
    stim[3]  = make_row('hf, 0, 0, 'haabb_ccdd, 'b0101, 1, 0, 'hf, 0, 'h00, 0);
    stim[4]  = make_row('hf, 1, 0, 'h0, 'hf, 1, 0, 'hf, 0, 'h00, 0);
    stim[5]  = make_row('b1010, 0, 1, 'h5500_0000, 'b1000, 1, 0, 'hf, 0, 'h00, 0);
    // clear while the round-robin counter sits at 2
    stim[6]  = make_row('hf, 1, 0, 'h0, 'hf, 2, 0, 'hf, 0, 'h00, 1);
    // forced ranks 2,0,3,1 then 3,2,1,0
    stim[7]  = make_row('hf, 0, 16, 'h7700_0000, 'hf, 1, 0, 'hf, 1, 'h72, 0);
    stim[8]  = make_row('b0110, 1, 16, 'h0, 'hf, 1, 0, 'hf, 1, 'h1b, 0);
    // one channel holds r_ready low
    stim[9]  = make_row('hf, 0, 24, 'h0, 'hf, 2, 1, 'b1101, 0, 'h00, 0);
    stim[10] = make_row('hf, 1, 24, 'h0, 'hf, 2, 0, 'b1011, 0, 'h00, 0);
    // every channel stalls the bank so the FIFO fills up
    stim[11] = make_row('hf, 0, 32, 'h0, 'hf, 3, 1, 'b0000, 0, 'h00, 0);
    stim[12] = make_row('hf, 1, 32, 'h0, 'hf, 3, 0, 'b0111, 0, 'h00, 0);
    stim[13] = make_row('hf, 1, 0, 'h0, 'hf, 1, 0, 'hf, 0, 'h00, 1);
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < n_rows; i++) begin
      apply_row(stim[i]);
    end
    run_end = 1'b1;
    @(negedge clk_i);
    run_end = 1'b0;
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(n_rows * 20 * clk_per);
    $display("run did not finish within %0d cycles", n_rows * 20);
    $display("Errors found");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+source
source/hci_pkg.sv
source/hci_ooo_mux.sv
source/hci_req_fifo.sv
source/hci_mem_bank.sv
source/hci_ooo_subsystem.sv
bench/tb_hci_checker.sv
bench/tb_hci_ooo.sv
